// ==== hdl/udp_pkg.sv ====
`default_nettype none

package udp_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;

    // Local station setup, held static by the surrounding system.
    typedef struct packed {
        mac_addr_t src_mac;
        ip_addr_t  src_ip;
        port_t     src_port;
        mac_addr_t dst_mac;
        ip_addr_t  dst_ip;
        port_t     dst_port_a;
        port_t     dst_port_b;
        len_t      frames_a;      // Frames sent to dst_port_a per round.
        len_t      frames_b;      // Frames sent to dst_port_b per round.
        len_t      payload_size;  // UDP payload bytes per frame.
    } udp_config_t;

    // Frame geometry.
    localparam len_t HEADER_BYTES = 16'd42;  // Ethernet 14, IPv4 20, UDP 8.
    localparam len_t IP_OVERHEAD  = 16'd28;
    localparam len_t UDP_OVERHEAD = 16'd8;

    // Fixed header field values.
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam byte_t       IP_PROTO_UDP   = 8'h11;
    localparam byte_t       IP_VER_IHL     = 8'h45;
    localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;
    localparam byte_t       IP_TTL         = 8'hff;
    localparam byte_t       BROADCAST_BYTE = 8'hff;

    // Byte offsets from the first byte of the destination MAC.
    localparam len_t OFS_ETHERTYPE = 16'd12;
    localparam len_t OFS_IP_PROTO  = 16'd23;
    localparam len_t OFS_DST_IP    = 16'd30;
    localparam len_t OFS_DST_PORT  = 16'd36;
    localparam len_t OFS_UDP_LEN   = 16'd38;

endpackage

`default_nettype wire

// ==== hdl/ipv4_checksum.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipv4_checksum (
    input  logic                 clk,
    input  logic                 reset,
    input  udp_pkg::udp_config_t cfg,
    output udp_pkg::port_t       checksum
);
    import udp_pkg::*;

    logic [31:0] word_sum;
    logic [31:0] fold_sum;
    len_t        total_len;

    assign total_len = cfg.payload_size + IP_OVERHEAD;

    always_ff @(posedge clk) begin
        if (reset) begin
            word_sum <= '0;
            fold_sum <= '0;
            checksum <= '0;
        end else begin
            // The identification word is zero and adds nothing to the sum.
            word_sum <= {16'h0000, IP_VER_IHL, 8'h00}
                      + {16'h0000, total_len}
                      + {16'h0000, IP_FLAGS_DF}
                      + {16'h0000, IP_TTL, IP_PROTO_UDP}
                      + {16'h0000, cfg.src_ip[31:16]}
                      + {16'h0000, cfg.src_ip[15:0]}
                      + {16'h0000, cfg.dst_ip[31:16]}
                      + {16'h0000, cfg.dst_ip[15:0]};
            fold_sum <= {16'h0000, word_sum[31:16]} + {16'h0000, word_sum[15:0]};
            checksum <= ~(fold_sum[31:16] + fold_sum[15:0]);  // Second fold absorbs the last carry.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/udp_port_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_port_scheduler (
    input  logic                 clk,
    input  logic                 reset,
    input  udp_pkg::udp_config_t cfg,
    input  logic                 header_done,
    output udp_pkg::port_t       dst_port
);
    import udp_pkg::*;

    len_t frame_count;
    logic port_sel;
    logic group_done;

    // The current group ends with the frame whose header is finishing now.
    assign group_done = port_sel ? (frame_count + 16'd1 == cfg.frames_b)
                                 : (frame_count + 16'd1 == cfg.frames_a);

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_count <= '0;
            port_sel    <= 1'b0;
        end else if (header_done) begin
            if (group_done) begin
                frame_count <= '0;
                port_sel    <= !port_sel;
            end else begin
                frame_count <= frame_count + 16'd1;
            end
        end
    end

    assign dst_port = port_sel ? cfg.dst_port_b : cfg.dst_port_a;

endmodule

`default_nettype wire

// ==== hdl/udp_tx_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_tx_framer (
    input  logic                 clk,
    input  logic                 reset,
    input  udp_pkg::udp_config_t cfg,
    input  udp_pkg::port_t       checksum,
    input  udp_pkg::port_t       dst_port,
    input  udp_pkg::byte_t       tx_streaming_data,
    input  logic                 tx_streaming_valid,
    output logic                 tx_streaming_ready,
    output udp_pkg::byte_t       master_data,
    output logic                 master_valid,
    output logic                 master_last,
    input  logic                 master_ready,
    output logic                 header_done
);
    import udp_pkg::*;

    len_t  pos;
    len_t  ip_len;
    len_t  udp_len;
    len_t  frame_end;
    logic  started;
    logic  load_ok;
    logic  in_payload;
    logic  hdr_end;
    byte_t hdr_byte;

    assign ip_len     = cfg.payload_size + IP_OVERHEAD;
    assign udp_len    = cfg.payload_size + UDP_OVERHEAD;
    assign frame_end  = HEADER_BYTES + cfg.payload_size - 16'd1;
    assign load_ok    = !master_valid || master_ready;  // Output register empty or draining.
    assign in_payload = pos >= HEADER_BYTES;

    assign tx_streaming_ready = in_payload && load_ok;
    assign header_done        = master_valid && master_ready && hdr_end;

    always_comb begin
        case (pos)
            16'd0:                  hdr_byte = cfg.dst_mac[47:40];
            16'd1:                  hdr_byte = cfg.dst_mac[39:32];
            16'd2:                  hdr_byte = cfg.dst_mac[31:24];
            16'd3:                  hdr_byte = cfg.dst_mac[23:16];
            16'd4:                  hdr_byte = cfg.dst_mac[15:8];
            16'd5:                  hdr_byte = cfg.dst_mac[7:0];
            16'd6:                  hdr_byte = cfg.src_mac[47:40];
            16'd7:                  hdr_byte = cfg.src_mac[39:32];
            16'd8:                  hdr_byte = cfg.src_mac[31:24];
            16'd9:                  hdr_byte = cfg.src_mac[23:16];
            16'd10:                 hdr_byte = cfg.src_mac[15:8];
            16'd11:                 hdr_byte = cfg.src_mac[7:0];
            OFS_ETHERTYPE:          hdr_byte = ETHERTYPE_IPV4[15:8];
            OFS_ETHERTYPE + 16'd1:  hdr_byte = ETHERTYPE_IPV4[7:0];
            16'd14:                 hdr_byte = IP_VER_IHL;
            16'd16:                 hdr_byte = ip_len[15:8];
            16'd17:                 hdr_byte = ip_len[7:0];
            16'd20:                 hdr_byte = IP_FLAGS_DF[15:8];
            16'd21:                 hdr_byte = IP_FLAGS_DF[7:0];
            16'd22:                 hdr_byte = IP_TTL;
            OFS_IP_PROTO:           hdr_byte = IP_PROTO_UDP;
            16'd24:                 hdr_byte = checksum[15:8];
            16'd25:                 hdr_byte = checksum[7:0];
            16'd26:                 hdr_byte = cfg.src_ip[31:24];
            16'd27:                 hdr_byte = cfg.src_ip[23:16];
            16'd28:                 hdr_byte = cfg.src_ip[15:8];
            16'd29:                 hdr_byte = cfg.src_ip[7:0];
            OFS_DST_IP:             hdr_byte = cfg.dst_ip[31:24];
            OFS_DST_IP + 16'd1:     hdr_byte = cfg.dst_ip[23:16];
            OFS_DST_IP + 16'd2:     hdr_byte = cfg.dst_ip[15:8];
            OFS_DST_IP + 16'd3:     hdr_byte = cfg.dst_ip[7:0];
            16'd34:                 hdr_byte = cfg.src_port[15:8];
            16'd35:                 hdr_byte = cfg.src_port[7:0];
            OFS_DST_PORT:           hdr_byte = dst_port[15:8];
            OFS_DST_PORT + 16'd1:   hdr_byte = dst_port[7:0];
            OFS_UDP_LEN:            hdr_byte = udp_len[15:8];
            OFS_UDP_LEN + 16'd1:    hdr_byte = udp_len[7:0];
            default:                hdr_byte = 8'h00;  // TOS, identification, UDP checksum.
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
        end else if (tx_streaming_valid) begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pos          <= '0;
            master_valid <= 1'b0;
            master_last  <= 1'b0;
            hdr_end      <= 1'b0;
        end else if (load_ok) begin
            if (started && !in_payload) begin
                master_valid <= 1'b1;
                master_last  <= 1'b0;
                hdr_end      <= (pos == HEADER_BYTES - 16'd1);
                pos          <= pos + 16'd1;
            end else if (in_payload && tx_streaming_valid) begin
                master_valid <= 1'b1;
                master_last  <= (pos == frame_end);
                hdr_end      <= 1'b0;
                pos          <= (pos == frame_end) ? '0 : pos + 16'd1;  // Next header follows at once.
            end else begin
                master_valid <= 1'b0;  // Payload starved, so the slot stays empty.
                master_last  <= 1'b0;
                hdr_end      <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ok) begin
            master_data <= in_payload ? tx_streaming_data : hdr_byte;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/udp_rx_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_rx_filter (
    input  logic                 clk,
    input  logic                 reset,
    input  udp_pkg::udp_config_t cfg,
    input  udp_pkg::byte_t       slave_data,
    input  logic                 slave_valid,
    input  logic                 slave_last,
    output logic                 slave_ready,
    output udp_pkg::byte_t       rx_streaming_data,
    output logic                 rx_streaming_valid,
    output logic                 rx_streaming_last,
    input  logic                 rx_streaming_ready
);
    import udp_pkg::*;

    len_t cnt;
    len_t udp_len;
    len_t last_ofs;
    logic reject;
    logic bad;
    logic take;
    logic in_payload;

    function automatic logic mac_ok(byte_t rx, byte_t ours);
        return (rx == BROADCAST_BYTE) || (rx == ours);
    endfunction

    assign take = slave_valid && slave_ready;

    // Payload runs from the end of the header through 8 bytes short of 42 plus the UDP length.
    assign last_ofs   = udp_len + HEADER_BYTES - UDP_OVERHEAD - 16'd1;
    assign in_payload = !reject && (cnt >= HEADER_BYTES) && (cnt <= last_ofs);

    always_comb begin
        case (cnt)
            16'd0:                 bad = !mac_ok(slave_data, cfg.src_mac[47:40]);
            16'd1:                 bad = !mac_ok(slave_data, cfg.src_mac[39:32]);
            16'd2:                 bad = !mac_ok(slave_data, cfg.src_mac[31:24]);
            16'd3:                 bad = !mac_ok(slave_data, cfg.src_mac[23:16]);
            16'd4:                 bad = !mac_ok(slave_data, cfg.src_mac[15:8]);
            16'd5:                 bad = !mac_ok(slave_data, cfg.src_mac[7:0]);
            OFS_ETHERTYPE:         bad = slave_data != ETHERTYPE_IPV4[15:8];
            OFS_ETHERTYPE + 16'd1: bad = slave_data != ETHERTYPE_IPV4[7:0];
            OFS_IP_PROTO:          bad = slave_data != IP_PROTO_UDP;
            OFS_DST_IP:            bad = slave_data != cfg.src_ip[31:24];
            OFS_DST_IP + 16'd1:    bad = slave_data != cfg.src_ip[23:16];
            OFS_DST_IP + 16'd2:    bad = slave_data != cfg.src_ip[15:8];
            OFS_DST_IP + 16'd3:    bad = slave_data != cfg.src_ip[7:0];
            OFS_DST_PORT:          bad = slave_data != cfg.src_port[15:8];
            OFS_DST_PORT + 16'd1:  bad = slave_data != cfg.src_port[7:0];
            default:               bad = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt    <= '0;
            reject <= 1'b0;
        end else if (take) begin
            if (slave_last) begin
                cnt    <= '0;
                reject <= 1'b0;  // Each frame is judged on its own.
            end else begin
                cnt <= cnt + 16'd1;
                if (bad) begin
                    reject <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && cnt == OFS_UDP_LEN) begin
            udp_len[15:8] <= slave_data;
        end
        if (take && cnt == OFS_UDP_LEN + 16'd1) begin
            udp_len[7:0] <= slave_data;
        end
    end

    // Outside the payload every byte is consumed and dropped.
    assign slave_ready        = in_payload ? rx_streaming_ready : 1'b1;
    assign rx_streaming_data  = slave_data;
    assign rx_streaming_valid = in_payload && slave_valid;
    assign rx_streaming_last  = in_payload && (cnt == last_ofs);

endmodule

`default_nettype wire

// ==== hdl/udp_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_stack (
    input  logic                 clk,
    input  logic                 reset,
    input  udp_pkg::udp_config_t cfg,
    input  udp_pkg::byte_t       tx_streaming_data,
    input  logic                 tx_streaming_valid,
    output logic                 tx_streaming_ready,
    output udp_pkg::byte_t       master_data,
    output logic                 master_valid,
    output logic                 master_last,
    input  logic                 master_ready,
    input  udp_pkg::byte_t       slave_data,
    input  logic                 slave_valid,
    input  logic                 slave_last,
    output logic                 slave_ready,
    output udp_pkg::byte_t       rx_streaming_data,
    output logic                 rx_streaming_valid,
    output logic                 rx_streaming_last,
    input  logic                 rx_streaming_ready
);
    import udp_pkg::*;

    port_t checksum;
    port_t dst_port;
    logic  header_done;

    ipv4_checksum u_checksum (
        .clk      (clk),
        .reset    (reset),
        .cfg      (cfg),
        .checksum (checksum)
    );

    udp_port_scheduler u_scheduler (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .header_done (header_done),
        .dst_port    (dst_port)
    );

    udp_tx_framer u_tx_framer (
        .clk                (clk),
        .reset              (reset),
        .cfg                (cfg),
        .checksum           (checksum),
        .dst_port           (dst_port),
        .tx_streaming_data  (tx_streaming_data),
        .tx_streaming_valid (tx_streaming_valid),
        .tx_streaming_ready (tx_streaming_ready),
        .master_data        (master_data),
        .master_valid       (master_valid),
        .master_last        (master_last),
        .master_ready       (master_ready),
        .header_done        (header_done)
    );

    udp_rx_filter u_rx_filter (
        .clk                (clk),
        .reset              (reset),
        .cfg                (cfg),
        .slave_data         (slave_data),
        .slave_valid        (slave_valid),
        .slave_last         (slave_last),
        .slave_ready        (slave_ready),
        .rx_streaming_data  (rx_streaming_data),
        .rx_streaming_valid (rx_streaming_valid),
        .rx_streaming_last  (rx_streaming_last),
        .rx_streaming_ready (rx_streaming_ready)
    );

endmodule

`default_nettype wire

// ==== tests/udp_stack_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_stack_tb;
    import udp_pkg::*;

    localparam int CFG_BITS = $bits(udp_config_t);
    localparam int TIMEOUT  = 4000;

    logic clk, reset;
    udp_config_t cfg;
    byte_t tx_data, master_data, slave_data, rx_data;
    logic tx_valid, tx_ready, master_valid, master_last, master_ready;
    logic slave_valid, slave_last, slave_ready, rx_valid, rx_last, rx_ready;

    byte_t mem [0:1023];
    byte_t tx_payload [0:63];
    byte_t exp_frame [0:127];
    byte_t rx_frame [0:127];
    byte_t rx_payload [0:63];
    byte_t cor_ofs [0:15];
    byte_t cor_val [0:15];
    byte_t rx_exp_q [$];
    int payload_size, frame_len, rx_len, rx_plen, num_cor;
    int tx_idx, tx_byte, tx_frames, ptr;
    logic tx_enable, random_mode;

    udp_stack u_dut (
        .clk(clk), .reset(reset), .cfg(cfg),
        .tx_streaming_data(tx_data), .tx_streaming_valid(tx_valid),
        .tx_streaming_ready(tx_ready),
        .master_data(master_data), .master_valid(master_valid),
        .master_last(master_last), .master_ready(master_ready),
        .slave_data(slave_data), .slave_valid(slave_valid),
        .slave_last(slave_last), .slave_ready(slave_ready),
        .rx_streaming_data(rx_data), .rx_streaming_valid(rx_valid),
        .rx_streaming_last(rx_last), .rx_streaming_ready(rx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = !clk;
    end

    task automatic abort_run(input string why);
        $display("Error: %s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // Walks the data file image in order, one byte per call.
    function automatic byte_t next_data_byte();
        byte_t b;
        b = mem[ptr];
        ptr++;
        return b;
    endfunction

    // Port a for the first frames_a frames of each round, then port b.
    function automatic port_t port_for_frame(input int k);
        int round;
        round = int'(cfg.frames_a) + int'(cfg.frames_b);
        return ((k % round) < int'(cfg.frames_a)) ? cfg.dst_port_a : cfg.dst_port_b;
    endfunction

    function automatic byte_t expected_tx_byte(input int k, input int n);
        port_t p;
        p = port_for_frame(k);
        if (k != 0 && n == int'(OFS_DST_PORT)) return p[15:8];
        if (k != 0 && n == int'(OFS_DST_PORT) + 1) return p[7:0];
        return exp_frame[n];
    endfunction

    function automatic logic [15:0] header_checksum();
        logic [31:0] sum;
        sum = '0;
        for (int i = 14; i < 34; i += 2) begin
            if (i != 24) sum += {16'h0000, exp_frame[i], exp_frame[i + 1]};
        end
        sum = {16'h0000, sum[31:16]} + {16'h0000, sum[15:0]};
        sum = {16'h0000, sum[31:16]} + {16'h0000, sum[15:0]};
        return ~sum[15:0];
    endfunction

    // Payload source; a pending byte is held until it is taken.
    always @(posedge clk) begin
        logic taken;
        taken = tx_valid && tx_ready;
        if (taken) tx_idx = (tx_idx + 1) % payload_size;
        #1;
        if (!tx_enable) tx_valid = 1'b0;
        else if (!(tx_valid && !taken)) tx_valid = random_mode ? 1'($urandom % 2) : 1'b1;
        tx_data = tx_payload[tx_idx];
    end

    always @(posedge clk) begin
        if (!reset && master_valid && master_ready) begin
            check_value("master_data", 16'(master_data), 16'(expected_tx_byte(tx_frames, tx_byte)));
            check_value("master_last", 16'(master_last), 16'(tx_byte == frame_len - 1));
            tx_byte++;
            if (tx_byte == frame_len) begin
                tx_byte = 0;
                tx_frames++;
            end
        end
        #1 master_ready = random_mode ? 1'($urandom % 2) : 1'b1;
    end

    always @(posedge clk) begin
        if (!reset && rx_valid) begin
            if (rx_exp_q.size() == 0) abort_run("rx_streaming_valid rose with no payload due");
            else if (rx_ready) begin
                check_value("rx_streaming_data", 16'(rx_data), 16'(rx_exp_q[0]));
                check_value("rx_streaming_last", 16'(rx_last), 16'(rx_exp_q.size() == 1));
                void'(rx_exp_q.pop_front());
            end
        end
        #1 rx_ready = 1'($urandom % 2);
    end

    task automatic wait_tx_frames(input int target);
        int cycles;
        cycles = 0;
        while (tx_frames < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) abort_run("timed out waiting for transmit frames");
        end
    endtask

    // Called and returning 1 ns after a rising edge.
    task automatic send_rx_frame(input logic corrupt, input int k);
        int cycles;
        for (int i = 0; i < rx_len; i++) begin
            slave_valid = 1'b1;
            slave_data  = (corrupt && i == int'(cor_ofs[k])) ? cor_val[k] : rx_frame[i];
            slave_last  = (i == rx_len - 1);
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                if (cycles > TIMEOUT) abort_run("slave_ready stayed low");
            end while (!slave_ready);
            #1;
        end
        slave_valid = 1'b0;
        slave_last  = 1'b0;
    endtask

    task automatic wait_rx_drained();
        int cycles;
        cycles = 0;
        while (rx_exp_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) abort_run("received payload did not arrive");
        end
    endtask

    initial begin
        logic [CFG_BITS-1:0] cfg_vec;
        int round;
        void'($urandom(32'hefe1_2121));
        {reset, tx_valid, tx_data, master_ready, tx_enable, random_mode} = '0;
        {slave_valid, slave_last, slave_data, rx_ready} = '0;
        reset = 1'b1;
        {tx_idx, tx_byte, tx_frames, ptr} = '0;
        $readmemh("tests/udp_testdata.hex", mem);
        cfg_vec = '0;
        for (int i = 0; i < CFG_BITS / 8; i++) cfg_vec = {cfg_vec[CFG_BITS-9:0], next_data_byte()};
        cfg = cfg_vec;
        payload_size = int'(cfg.payload_size);
        frame_len = int'(HEADER_BYTES) + payload_size;
        for (int i = 0; i < payload_size; i++) tx_payload[i] = next_data_byte();
        for (int i = 0; i < frame_len; i++) exp_frame[i] = next_data_byte();
        rx_len = int'(next_data_byte());
        for (int i = 0; i < rx_len; i++) rx_frame[i] = next_data_byte();
        rx_plen = int'(next_data_byte());
        for (int i = 0; i < rx_plen; i++) rx_payload[i] = next_data_byte();
        num_cor = int'(next_data_byte());
        for (int i = 0; i < num_cor; i++) begin
            cor_ofs[i] = next_data_byte();
            cor_val[i] = next_data_byte();
        end
        check_value("ip_checksum", {exp_frame[24], exp_frame[25]}, header_checksum());
        round = int'(cfg.frames_a) + int'(cfg.frames_b) + 2;

        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        check_value("master_valid", 16'(master_valid), 16'h0000);
        check_value("master_last", 16'(master_last), 16'h0000);
        check_value("tx_streaming_ready", 16'(tx_ready), 16'h0000);
        check_value("rx_streaming_valid", 16'(rx_valid), 16'h0000);
        check_value("slave_ready", 16'(slave_ready), 16'h0001);
        repeat (4) @(posedge clk);  // Checksum pipeline settles.
        #1 tx_enable = 1'b1;
        wait_tx_frames(round);
        random_mode = 1'b1;
        wait_tx_frames(2 * round);

        @(posedge clk);
        #1;
        for (int i = 0; i < rx_plen; i++) rx_exp_q.push_back(rx_payload[i]);
        send_rx_frame(1'b0, 0);
        wait_rx_drained();
        for (int k = 0; k < num_cor; k++) send_rx_frame(1'b1, k);
        for (int i = 0; i < rx_plen; i++) rx_exp_q.push_back(rx_payload[i]);
        send_rx_frame(1'b0, 0);
        wait_rx_drained();
        repeat (5) @(posedge clk);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/udp_pkg.sv
hdl/ipv4_checksum.sv
hdl/udp_port_scheduler.sv
hdl/udp_tx_framer.sv
hdl/udp_rx_filter.sv
hdl/udp_stack.sv
tests/udp_stack_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = udp_stack_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up in the simulator output.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/udp_testdata.hex ====
// Bytes in order: config (32), transmit payload, expected first frame, receive frame length
// and bytes, expected payload length and bytes, corruption count, then offset/value pairs.
// Config: src_mac src_ip src_port, dst_mac dst_ip port_a port_b, frames_a frames_b payload.
02 00 00 00 00 01 c0 a8 01 0a 04 d2
02 00 00 00 00 02 c0 a8 01 14 13 88 17 70
00 02 00 03 00 06
// Transmit payload.
a1 b2 c3 d4 e5 f6
// Expected first frame: Ethernet, IPv4 (checksum f85b), UDP, payload.
02 00 00 00 00 02 02 00 00 00 00 01 08 00
45 00 00 22 00 00 40 00 ff 11 f8 5b
c0 a8 01 0a c0 a8 01 14
04 d2 13 88 00 0e 00 00
a1 b2 c3 d4 e5 f6
// Receive frame, 50 bytes with 3 bytes of padding.
32
02 00 00 00 00 01 02 00 00 00 00 09 08 00
45 00 00 21 00 00 40 00 40 11 00 00
c0 a8 01 14 c0 a8 01 0a
13 88 04 d2 00 0d 00 00
11 22 33 44 55
00 00 00
// Expected receive payload.
05
11 22 33 44 55
// Corruptions: MAC, EtherType, protocol, destination IP, destination port.
05
05 07
0c 86
17 06
21 0b
25 d3
